//--- src/mdu_pkg.sv
package mdu_pkg;

	// RV64 register width.
	localparam int xlen = 64;

	typedef logic [xlen-1:0]   xword_t; // One register value.
	typedef logic [2*xlen-1:0] dword_t; // Full multiplier product.

	// M-extension funct3 codes.
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} mdu_op_e;

endpackage

//--- src/mdu_op_latch.sv
`timescale 1ns/1ps

module mdu_op_latch (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              in_valid,
	input  logic              flush,
	input  logic              word,
	input  logic              done,
	input  mdu_pkg::mdu_op_e  op,
	input  mdu_pkg::xword_t   rs2,
	output logic              in_ready,
	output logic              is_div,
	output logic              start_mul,
	output logic              start_div,
	output logic              word_q,
	output logic              take_rem,
	output logic              high_half,
	output logic              signed_a,
	output logic              signed_b,
	output logic              divisor_zero
);
	import mdu_pkg::*;

	logic busy;
	logic accept;
	logic rs2_zero;

	assign is_div    = op[2];                          // Upper half of the funct3 space.
	assign accept    = in_valid & ~busy & ~flush;      // Flush wins over a new operation.
	assign start_div = accept & is_div;
	assign start_mul = accept & ~is_div;
	assign in_ready  = ~busy;
	assign rs2_zero  = word ? (rs2[31:0] == 32'd0) : (rs2 == '0);

	// Operand signedness, sampled by the engines on their start strobe.
	always_comb begin
		case (op)
			op_mulhsu: begin
				signed_a = 1'b1;
				signed_b = 1'b0;
			end
			op_mulhu, op_divu, op_remu: begin
				signed_a = 1'b0;
				signed_b = 1'b0;
			end
			default: begin
				signed_a = 1'b1;
				signed_b = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy         <= 1'b0;
			word_q       <= 1'b0;
			take_rem     <= 1'b0;
			high_half    <= 1'b0;
			divisor_zero <= 1'b0;
		end else if (flush || done) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy         <= 1'b1;
			word_q       <= word;
			take_rem     <= is_div & op[1];      // REM and REMU.
			high_half    <= ~is_div & (op != op_mul);
			divisor_zero <= is_div & rs2_zero;
		end
	end

endmodule

//--- src/radix2_divider.sv
`timescale 1ns/1ps

module radix2_divider (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            start,
	input  logic            flush,
	input  logic            word,
	input  logic            signed_op,
	input  mdu_pkg::xword_t dividend,
	input  mdu_pkg::xword_t divisor,
	output logic            done,
	output mdu_pkg::xword_t quotient,
	output mdu_pkg::xword_t remainder
);
	import mdu_pkg::*;

	logic                a_neg;
	logic                b_neg;
	xword_t              dvd_mag;
	xword_t              dsr_mag;
	logic [2*xlen-1:0]   part_rem; // Partial remainder over shifted dividend.
	xword_t              dsr_q;
	xword_t              quo_q;
	logic [xlen:0]       trial;
	logic [6:0]          count;
	logic                busy;
	logic                word_r;
	logic                neg_quo;
	logic                neg_rem;

	// Magnitudes of the operands.
	always_comb begin
		if (word) begin
			a_neg   = signed_op & dividend[31];
			b_neg   = signed_op & divisor[31];
			// Dividend sits in the upper half so 32 shifts bring it into place.
			dvd_mag = {(a_neg ? -dividend[31:0] : dividend[31:0]), 32'd0};
			dsr_mag = {32'd0, (b_neg ? -divisor[31:0] : divisor[31:0])};
		end else begin
			a_neg   = signed_op & dividend[xlen-1];
			b_neg   = signed_op & divisor[xlen-1];
			dvd_mag = a_neg ? -dividend : dividend;
			dsr_mag = b_neg ? -divisor : divisor;
		end
	end

	// Trial subtraction at the top of the partial remainder.
	assign trial = part_rem[2*xlen-1:xlen-1] - {1'b0, dsr_q};

	assign done = busy & (count == (word_r ? 7'd32 : 7'd64));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy    <= 1'b0;
			count   <= 7'd0;
			word_r  <= 1'b0;
			neg_quo <= 1'b0;
			neg_rem <= 1'b0;
		end else if (flush || done) begin
			busy    <= 1'b0;
			count   <= 7'd0;
			word_r  <= 1'b0;
			neg_quo <= 1'b0;
			neg_rem <= 1'b0;
		end else if (start) begin
			busy    <= 1'b1;
			count   <= 7'd0;
			word_r  <= word;
			neg_quo <= a_neg ^ b_neg;
			neg_rem <= a_neg;       // Remainder takes the dividend's sign.
		end else if (busy) begin
			count <= count + 7'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			part_rem <= {{xlen{1'b0}}, dvd_mag};
			dsr_q    <= dsr_mag;
			quo_q    <= '0;
		end else if (busy) begin
			if (trial[xlen]) begin
				part_rem <= {part_rem[2*xlen-2:0], 1'b0}; // Borrow, keep as is.
			end else begin
				part_rem <= {trial[xlen-1:0], part_rem[xlen-2:0], 1'b0};
			end
			quo_q <= {quo_q[xlen-2:0], ~trial[xlen]};
		end
	end

	assign quotient  = done ? (neg_quo ? -quo_q : quo_q) : '0;
	assign remainder = done ? (neg_rem ? -part_rem[2*xlen-1:xlen] : part_rem[2*xlen-1:xlen])
	                        : '0;

endmodule

//--- src/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            start,
	input  logic            flush,
	input  logic            word,
	input  logic            signed_a,
	input  logic            signed_b,
	input  mdu_pkg::xword_t multiplicand,
	input  mdu_pkg::xword_t multiplier,
	output logic            done,
	output mdu_pkg::dword_t product
);
	import mdu_pkg::*;

	logic       a_neg;
	logic       b_neg;
	xword_t     a_mag;
	xword_t     b_mag;
	dword_t     mcand_q;  // Shifted left once per step.
	xword_t     mplr_q;   // Shifted right once per step.
	dword_t     acc_q;
	logic [6:0] count;
	logic       busy;
	logic       word_r;
	logic       neg_prod;

	always_comb begin
		if (word) begin
			a_neg = signed_a & multiplicand[31];
			b_neg = signed_b & multiplier[31];
			a_mag = {32'd0, (a_neg ? -multiplicand[31:0] : multiplicand[31:0])};
			b_mag = {32'd0, (b_neg ? -multiplier[31:0] : multiplier[31:0])};
		end else begin
			a_neg = signed_a & multiplicand[xlen-1];
			b_neg = signed_b & multiplier[xlen-1];
			a_mag = a_neg ? -multiplicand : multiplicand;
			b_mag = b_neg ? -multiplier : multiplier;
		end
	end

	assign done = busy & (count == (word_r ? 7'd32 : 7'd64));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			count    <= 7'd0;
			word_r   <= 1'b0;
			neg_prod <= 1'b0;
		end else if (flush || done) begin
			busy     <= 1'b0;
			count    <= 7'd0;
			word_r   <= 1'b0;
			neg_prod <= 1'b0;
		end else if (start) begin
			busy     <= 1'b1;
			count    <= 7'd0;
			word_r   <= word;
			neg_prod <= a_neg ^ b_neg;
		end else if (busy) begin
			count <= count + 7'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand_q <= {{xlen{1'b0}}, a_mag};
			mplr_q  <= b_mag;
			acc_q   <= '0;
		end else if (busy) begin
			if (mplr_q[0])
				acc_q <= acc_q + mcand_q; // Add under the current multiplier bit.
			mcand_q <= {mcand_q[2*xlen-2:0], 1'b0};
			mplr_q  <= {1'b0, mplr_q[xlen-1:1]};
		end
	end

	assign product = done ? (neg_prod ? -acc_q : acc_q) : '0;

endmodule

//--- src/mdu_result_format.sv
`timescale 1ns/1ps

module mdu_result_format (
	input  logic            mul_done,
	input  logic            div_done,
	input  logic            take_rem,
	input  logic            high_half,
	input  logic            word_q,
	input  logic            divisor_zero,
	input  mdu_pkg::xword_t quotient,
	input  mdu_pkg::xword_t remainder,
	input  mdu_pkg::dword_t product,
	output logic            out_valid,
	output mdu_pkg::xword_t result
);
	import mdu_pkg::*;

	xword_t div_res;
	xword_t mul_res;
	xword_t sel;

	// Quotient of a division by zero is all ones.
	// The remainder already holds the dividend.
	always_comb begin
		if (take_rem)
			div_res = remainder;
		else if (divisor_zero)
			div_res = '1;
		else
			div_res = quotient;
	end

	assign mul_res = high_half ? product[2*xlen-1:xlen] : product[xlen-1:0];

	always_comb begin
		sel = div_done ? div_res : mul_res;
		if (word_q)
			sel = {{(xlen-32){sel[31]}}, sel[31:0]}; // Sign-extend W results.
	end

	assign out_valid = mul_done | div_done;
	assign result    = out_valid ? sel : '0;

endmodule

//--- src/mdu_top.sv
`timescale 1ns/1ps

module mdu_top (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             in_valid,
	input  logic             word,
	input  logic             flush,
	input  mdu_pkg::mdu_op_e op,
	input  mdu_pkg::xword_t  rs1,
	input  mdu_pkg::xword_t  rs2,
	output logic             in_ready,
	output logic             out_valid,
	output mdu_pkg::xword_t  result
);
	import mdu_pkg::*;

	logic   start_mul;
	logic   start_div;
	logic   word_q;
	logic   take_rem;
	logic   high_half;
	logic   signed_a;
	logic   signed_b;
	logic   divisor_zero;
	logic   mul_done;
	logic   div_done;
	xword_t quotient;
	xword_t remainder;
	dword_t product;

	mdu_op_latch op_latch_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.flush        (flush),
		.word         (word),
		.done         (out_valid),    // Either engine finishing ends the operation.
		.op           (op),
		.rs2          (rs2),
		.in_ready     (in_ready),
		.is_div       (),
		.start_mul    (start_mul),
		.start_div    (start_div),
		.word_q       (word_q),
		.take_rem     (take_rem),
		.high_half    (high_half),
		.signed_a     (signed_a),
		.signed_b     (signed_b),
		.divisor_zero (divisor_zero)
	);

	radix2_divider divider_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start_div),
		.flush     (flush),
		.word      (word),
		.signed_op (signed_a),      // Both operands share the sign mode here.
		.dividend  (rs1),
		.divisor   (rs2),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	shift_add_multiplier multiplier_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start_mul),
		.flush        (flush),
		.word         (word),
		.signed_a     (signed_a),
		.signed_b     (signed_b),
		.multiplicand (rs1),
		.multiplier   (rs2),
		.done         (mul_done),
		.product      (product)
	);

	mdu_result_format format_inst (
		.mul_done     (mul_done),
		.div_done     (div_done),
		.take_rem     (take_rem),
		.high_half    (high_half),
		.word_q       (word_q),
		.divisor_zero (divisor_zero),
		.quotient     (quotient),
		.remainder    (remainder),
		.product      (product),
		.out_valid    (out_valid),
		.result       (result)
	);

endmodule

//--- tb/mdu_asserts.sv
`timescale 1ns/1ps

module mdu_asserts (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic in_ready,
	input logic flush,
	input logic out_valid
);

	logic pending; // Accepted operation still in flight.
	logic flushed; // Flushed, and no acceptance since.
	int   fail_count = 0; // Assertion failures so far.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			flushed <= 1'b0;
		end else if (flush) begin
			pending <= 1'b0;
			flushed <= 1'b1;
		end else if (in_valid && in_ready) begin
			pending <= 1'b1;
			flushed <= 1'b0;
		end else if (out_valid) begin
			pending <= 1'b0;
		end
	end

	single_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) out_valid |=> !out_valid
	) else begin
		fail_count++;
		$error("out_valid stayed high for more than one cycle");
	end

	busy_level: assert property (
		@(posedge clk) disable iff (!arst_n) pending |-> !in_ready
	) else begin
		fail_count++;
		$error("in_ready went high while an operation was in flight");
	end

	quiet_after_flush: assert property (
		@(posedge clk) disable iff (!arst_n) flushed |-> !out_valid
	) else begin
		fail_count++;
		$error("out_valid appeared after a flush without a new operation");
	end

endmodule

bind mdu_top mdu_asserts mdu_asserts_inst (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.flush     (flush),
	.out_valid (out_valid)
);

//--- tb/mdu_tb.sv
`timescale 1ns/1ps

module mdu_tb;
	import mdu_pkg::*;

	logic    clk;
	logic    arst_n;
	logic    in_valid;
	logic    word;
	logic    flush;
	mdu_op_e op;
	xword_t  rs1;
	xword_t  rs2;
	logic    in_ready;
	logic    out_valid;
	xword_t  result;
	int      seed;
	int      errors;
	int      timeouts;

	localparam xword_t min64 = {1'b1, 63'd0}; // Most negative 64-bit value.

	mdu_top mdu_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.word      (word),
		.flush     (flush),
		.op        (op),
		.rs1       (rs1),
		.rs2       (rs2),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic xword_t rnd();
		return {$random(seed), $random(seed)};
	endfunction

	// Expected result from the RISC-V M-extension rules.
	function automatic xword_t ref_result(input mdu_op_e o, input logic w, input xword_t a,
	                                      input xword_t b);
		xword_t       x;
		xword_t       y;
		xword_t       r;
		logic [127:0] p;
		logic         uns;
		logic         ovf;
		uns = (o == op_divu) || (o == op_remu);
		x   = w ? (uns ? {32'd0, a[31:0]} : {{32{a[31]}}, a[31:0]}) : a;
		y   = w ? (uns ? {32'd0, b[31:0]} : {{32{b[31]}}, b[31:0]}) : b;
		ovf = (x == min64) && (y == '1);
		case (o)
			op_mulh:   p = {{64{x[63]}}, x} * {{64{y[63]}}, y};
			op_mulhsu: p = {{64{x[63]}}, x} * {64'd0, y};
			default:   p = {64'd0, x} * {64'd0, y};
		endcase
		case (o)
			op_mul: r = p[63:0];
			op_mulh, op_mulhsu, op_mulhu: r = p[127:64];
			op_div: begin
				if (y == '0) r = '1;
				else if (ovf) r = x;
				else r = $signed(x) / $signed(y);
			end
			op_divu: r = (y == '0) ? '1 : x / y;
			op_rem: begin
				if (y == '0) r = x;
				else if (ovf) r = '0;
				else r = $signed(x) % $signed(y);
			end
			default: r = (y == '0) ? x : x % y;
		endcase
		if (w)
			r = {{32{r[31]}}, r[31:0]};
		return r;
	endfunction

	task automatic check_result(input xword_t got, input xword_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!in_ready && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!in_ready) begin
			timeouts++;
			$display("Timeout at %0t: unit never became ready", $time);
		end
	endtask

	// Drives one operation and returns just after its accepting edge.
	task automatic send_op(input mdu_op_e o, input logic w, input xword_t a, input xword_t b);
		wait_ready();
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= o;
		word     <= w;
		rs1      <= a;
		rs2      <= b;
		@(posedge clk); // Accepting edge.
		in_valid <= 1'b0;
	endtask

	// A stray in_valid pulse goes in after poke_at cycles, none when negative.
	task automatic run_op(input mdu_op_e o, input logic w, input xword_t a, input xword_t b,
	                      input int poke_at);
		int     n;
		string  tag;
		xword_t exp;
		exp = ref_result(o, w, a, b);
		tag = $sformatf("%s word=%0b a=%h b=%h", o.name(), w, a, b);
		send_op(o, w, a, b);
		n = 0;
		@(negedge clk);
		while (!out_valid && n < 100) begin
			check_flag(in_ready, 1'b0, {"in_ready while busy, ", tag});
			if (n == poke_at) begin
				@(posedge clk);
				in_valid <= 1'b1;
				op       <= op_divu;
				rs1      <= rnd();
				rs2      <= rnd();
			end else if (n == poke_at + 1) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
			@(negedge clk);
			n++;
		end
		if (!out_valid) begin
			timeouts++;
			$display("Timeout at %0t: no result for %s", $time, tag);
		end else begin
			check_result(result, exp, tag);
			check_flag(in_ready, 1'b0, {"in_ready with result, ", tag});
			if (n != (w ? 32 : 64)) begin
				errors++;
				$display("Mismatch at %0t: latency %0d for %s", $time, n, tag);
			end
			@(negedge clk);
			check_flag(out_valid, 1'b0, {"out_valid one cycle later, ", tag});
			check_flag(in_ready, 1'b1, {"in_ready after result, ", tag});
		end
	endtask

	task automatic flush_op(input mdu_op_e o, input logic w, input xword_t a, input xword_t b);
		send_op(o, w, a, b);
		repeat (20) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk); // Flush edge.
		flush <= 1'b0;
		@(negedge clk);
		check_flag(in_ready, 1'b1, "in_ready after flush");
		repeat (70) begin
			check_flag(out_valid, 1'b0, "out_valid after flush");
			@(negedge clk);
		end
		run_op(o, w, a, b, -1);
	endtask

	task automatic test_full_div();
		mdu_op_e ops[4];
		xword_t  a[4];
		xword_t  b[4];
		ops = '{op_div, op_divu, op_rem, op_remu};
		a   = '{-64'sd7, 64'sd7, min64, -64'sd100};
		b   = '{64'sd2, -64'sd2, -64'sd1, -64'sd7};
		foreach (ops[i]) begin
			foreach (a[j])
				run_op(ops[i], 1'b0, a[j], b[j], -1);
			repeat (4) run_op(ops[i], 1'b0, rnd(), rnd(), -1);
			run_op(ops[i], 1'b0, rnd(), rnd() >> 40, -1); // Small divisor.
		end
	endtask

	task automatic test_word_ops();
		mdu_op_e ops[5];
		ops = '{op_div, op_rem, op_divu, op_remu, op_mul};
		foreach (ops[i]) begin
			run_op(ops[i], 1'b1, {32'hffff_0000, -32'sd20}, {32'h1234_5678, 32'sd3}, -1);
			run_op(ops[i], 1'b1, {32'h0000_abcd, 32'h8000_0000}, {32'h0, 32'hffff_ffff}, -1);
			repeat (4) run_op(ops[i], 1'b1, rnd(), rnd(), -1);
		end
	endtask

	task automatic test_div_zero();
		mdu_op_e ops[4];
		ops = '{op_div, op_divu, op_rem, op_remu};
		foreach (ops[i]) begin
			run_op(ops[i], 1'b0, rnd(), '0, -1);
			run_op(ops[i], 1'b0, min64 | 64'd77, '0, -1);
			run_op(ops[i], 1'b1, rnd(), {32'h5a5a_5a5a, 32'd0}, -1); // Only low half is zero.
			run_op(ops[i], 1'b1, {32'd9, 32'hffff_fff0}, {32'h1, 32'd0}, -1);
		end
	endtask

	task automatic test_mul();
		mdu_op_e ops[4];
		xword_t  a[5];
		xword_t  b[5];
		ops = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
		a   = '{64'd0, '1, min64, min64, '1};
		b   = '{64'h1234_5678_9abc_def0, '1, min64, '1, min64};
		foreach (ops[i]) begin
			foreach (a[j])
				run_op(ops[i], 1'b0, a[j], b[j], -1);
			repeat (4) run_op(ops[i], 1'b0, rnd(), rnd(), -1);
		end
	endtask

	initial begin
		seed     = 69233;
		errors   = 0;
		timeouts = 0;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		word     = 1'b0;
		flush    = 1'b0;
		op       = op_mul;
		rs1      = '0;
		rs2      = '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag(in_ready, 1'b1, "in_ready after reset");
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_result(result, '0, "result after reset");
		test_full_div();
		test_word_ops();
		test_div_zero();
		test_mul();
		run_op(op_rem, 1'b0, -64'sd1000, 64'sd33, 10);    // Stray in_valid while busy.
		run_op(op_mul, 1'b1, rnd(), rnd(), 5);
		flush_op(op_div, 1'b0, rnd(), rnd());
		flush_op(op_mulhu, 1'b0, rnd(), rnd());
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures", errors,
		         timeouts, mdu_top_inst.mdu_asserts_inst.fail_count);
		if (errors == 0 && timeouts == 0 && mdu_top_inst.mdu_asserts_inst.fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- vlog.f
src/mdu_pkg.sv
src/mdu_op_latch.sv
src/radix2_divider.sv
src/shift_add_multiplier.sv
src/mdu_result_format.sv
src/mdu_top.sv
tb/mdu_asserts.sv
tb/mdu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mdu_tb -f vlog.f -o mdu_sim
./obj_dir/mdu_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation did not pass, see sim.log"
	exit 1
fi
